// ==== src/vred_pkg.sv ====
`default_nettype none

package vred_pkg;

    // Vector geometry
    localparam int lanes      = 16;
    localparam int tree_depth = $clog2(lanes);

    // Input register, one register per tree level, output register
    localparam int tree_latency = tree_depth + 2;

    typedef logic [15:0] elem_t;
    typedef logic [4:0]  vlen_t;

    typedef enum logic [1:0] {
        red_sum = 2'd0,
        red_max = 2'd1,
        red_min = 2'd2,
        red_and = 2'd3
    } red_op_t;

    // Value that leaves the other operand unchanged
    function automatic elem_t identity_of(red_op_t op);
        case (op)
            red_sum: return 16'h0000;
            red_max: return 16'h8000;
            red_min: return 16'h7fff;
            default: return 16'hffff;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/vred_lane_mask.sv ====
`default_nettype none

module vred_lane_mask (
    input  wire                    CLK,
    input  wire                    nRST,
    input  wire                    valid_in,
    input  wire vred_pkg::red_op_t op,
    input  wire vred_pkg::vlen_t   vl,
    input  wire vred_pkg::elem_t   seed,
    input  wire vred_pkg::elem_t   elems [vred_pkg::lanes],
    output logic                   m_valid,
    output vred_pkg::red_op_t      m_op,
    output vred_pkg::elem_t        m_seed,
    output vred_pkg::elem_t        m_elems [vred_pkg::lanes]
);

    vred_pkg::elem_t ident;

    assign ident = vred_pkg::identity_of(op);

    // ------------------------------------------------------------------
    // Request register
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            m_valid <= 1'b0;
            m_op    <= vred_pkg::red_sum;
            m_seed  <= '0;
            for (int i = 0; i < vred_pkg::lanes; i++) begin
                m_elems[i] <= '0;
            end
        end else begin
            m_valid <= valid_in;
            if (valid_in) begin
                m_op   <= op;
                m_seed <= seed;
                // Lanes from vl upward take the identity
                for (int i = 0; i < vred_pkg::lanes; i++) begin
                    if (vred_pkg::vlen_t'(i) < vl) begin
                        m_elems[i] <= elems[i];
                    end else begin
                        m_elems[i] <= ident;
                    end
                end
            end
        end
    end

    // Active count must fit the vector
    a_vl_range: assert property (
        @(posedge CLK) disable iff (!nRST)
        valid_in |-> (vl <= vred_pkg::vlen_t'(vred_pkg::lanes))
    ) else $error("active count %0d exceeds lane count", vl);

endmodule

`default_nettype wire

// ==== src/vred_pair_alu.sv ====
`default_nettype none

module vred_pair_alu (
    input  wire vred_pkg::elem_t   a,
    input  wire vred_pkg::elem_t   b,
    input  wire vred_pkg::red_op_t op,
    output vred_pkg::elem_t        y
);

    logic signed [15:0] a_s;
    logic signed [15:0] b_s;
    logic               a_gt_b;

    assign a_s = a;
    assign b_s = b;

    // Signed compare shared by max and min
    assign a_gt_b = (a_s > b_s);

    always_comb begin
        case (op)
            vred_pkg::red_sum: begin
                // Wraps at 16 bits
                y = a + b;
            end
            vred_pkg::red_max: begin
                y = a_gt_b ? a : b;
            end
            vred_pkg::red_min: begin
                y = a_gt_b ? b : a;
            end
            default: begin
                // Bitwise AND
                y = a & b;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/vred_tree.sv ====
`default_nettype none

module vred_tree (
    input  wire                    CLK,
    input  wire                    nRST,
    input  wire                    valid_in,
    input  wire vred_pkg::red_op_t op,
    input  wire vred_pkg::elem_t   data [vred_pkg::lanes],
    output vred_pkg::elem_t        sum,
    output logic                   valid_out
);

    // All tree levels packed into one node array.
    // Level k starts at span - (span >> k), level 0 is the input register
    localparam int span  = 2 * vred_pkg::lanes;
    localparam int nodes = span - 1;

    vred_pkg::elem_t   node        [nodes];
    vred_pkg::elem_t   alu_y       [vred_pkg::lanes - 1];
    vred_pkg::red_op_t stage_op    [vred_pkg::tree_depth];
    logic              stage_valid [vred_pkg::tree_depth + 1];

    // ------------------------------------------------------------------
    // Input register and level registers
    // ------------------------------------------------------------------
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int n = 0; n < nodes; n++) begin
                node[n] <= '0;
            end
            for (int l = 0; l < vred_pkg::tree_depth; l++) begin
                stage_op[l] <= vred_pkg::red_sum;
            end
            for (int l = 0; l <= vred_pkg::tree_depth; l++) begin
                stage_valid[l] <= 1'b0;
            end
        end else begin
            // Leaves hold their value between vectors
            if (valid_in) begin
                for (int i = 0; i < vred_pkg::lanes; i++) begin
                    node[i] <= data[i];
                end
                stage_op[0] <= op;
            end
            stage_valid[0] <= valid_in;

            // Pair results and control move one level every cycle
            for (int n = 0; n < vred_pkg::lanes - 1; n++) begin
                node[vred_pkg::lanes + n] <= alu_y[n];
            end
            for (int l = 1; l < vred_pkg::tree_depth; l++) begin
                stage_op[l] <= stage_op[l - 1];
            end
            for (int l = 1; l <= vred_pkg::tree_depth; l++) begin
                stage_valid[l] <= stage_valid[l - 1];
            end
        end
    end

    // ------------------------------------------------------------------
    // Pair ALUs, one row per level
    // ------------------------------------------------------------------
    for (genvar l = 0; l < vred_pkg::tree_depth; l++) begin : g_level
        localparam int in_off  = span - (span >> l);
        localparam int out_off = span - (span >> (l + 1)) - vred_pkg::lanes;

        for (genvar j = 0; j < (vred_pkg::lanes >> (l + 1)); j++) begin : g_pair
            vred_pair_alu u_alu (
                .a  (node[in_off + 2 * j]),
                .b  (node[in_off + 2 * j + 1]),
                .op (stage_op[l]),
                .y  (alu_y[out_off + j])
            );
        end

        // Op travelling with a live vector
        a_op_known: assert property (
            @(posedge CLK) disable iff (!nRST)
            stage_valid[l] |-> !$isunknown(stage_op[l])
        ) else $error("unknown op at tree level %0d", l);
    end

    // Root of the tree
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            sum       <= '0;
            valid_out <= 1'b0;
        end else begin
            sum       <= node[nodes - 1];
            valid_out <= stage_valid[vred_pkg::tree_depth];
        end
    end

endmodule

`default_nettype wire

// ==== src/vred_seed_combine.sv ====
`default_nettype none

module vred_seed_combine (
    input  wire                    CLK,
    input  wire                    nRST,
    input  wire                    valid_in,
    input  wire vred_pkg::red_op_t op,
    input  wire vred_pkg::elem_t   seed,
    input  wire vred_pkg::elem_t   tree_sum,
    input  wire                    tree_valid,
    output vred_pkg::elem_t        result,
    output logic                   result_valid
);

    localparam int last = vred_pkg::tree_latency - 1;

    vred_pkg::elem_t   d_seed  [vred_pkg::tree_latency];
    vred_pkg::red_op_t d_op    [vred_pkg::tree_latency];
    logic              d_valid [vred_pkg::tree_latency];
    vred_pkg::elem_t   comb_y;

    // Seed folded in as one more pair
    vred_pair_alu u_alu (
        .a  (d_seed[last]),
        .b  (tree_sum),
        .op (d_op[last]),
        .y  (comb_y)
    );

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < vred_pkg::tree_latency; i++) begin
                d_seed[i]  <= '0;
                d_op[i]    <= vred_pkg::red_sum;
                d_valid[i] <= 1'b0;
            end
            result       <= '0;
            result_valid <= 1'b0;
        end else begin
            d_seed[0]  <= seed;
            d_op[0]    <= op;
            d_valid[0] <= valid_in;
            for (int i = 1; i < vred_pkg::tree_latency; i++) begin
                d_seed[i]  <= d_seed[i - 1];
                d_op[i]    <= d_op[i - 1];
                d_valid[i] <= d_valid[i - 1];
            end
            result_valid <= tree_valid;
            if (tree_valid) begin
                result <= comb_y;
            end
        end
    end

    // Delay line and tree must stay in step
    a_path_align: assert property (
        @(posedge CLK) disable iff (!nRST)
        tree_valid == d_valid[last]
    ) else $error("tree result out of step with seed delay line");

endmodule

`default_nettype wire

// ==== src/vred_top.sv ====
`default_nettype none

module vred_top (
    input  wire                    CLK,
    input  wire                    nRST,
    input  wire                    valid_in,
    input  wire vred_pkg::red_op_t op,
    input  wire vred_pkg::vlen_t   vl,
    input  wire vred_pkg::elem_t   seed,
    input  wire vred_pkg::elem_t   elems [vred_pkg::lanes],
    output vred_pkg::elem_t        result,
    output logic                   result_valid
);

    // Masked request
    vred_pkg::elem_t   m_elems [vred_pkg::lanes];
    vred_pkg::red_op_t m_op;
    vred_pkg::elem_t   m_seed;
    logic              m_valid;

    // Tree output
    vred_pkg::elem_t   t_sum;
    logic              t_valid;

    vred_lane_mask u_lane_mask (
        .CLK      (CLK),
        .nRST     (nRST),
        .valid_in (valid_in),
        .op       (op),
        .vl       (vl),
        .seed     (seed),
        .elems    (elems),
        .m_valid  (m_valid),
        .m_op     (m_op),
        .m_seed   (m_seed),
        .m_elems  (m_elems)
    );

    vred_tree u_tree (
        .CLK       (CLK),
        .nRST      (nRST),
        .valid_in  (m_valid),
        .op        (m_op),
        .data      (m_elems),
        .sum       (t_sum),
        .valid_out (t_valid)
    );

    vred_seed_combine u_seed_combine (
        .CLK          (CLK),
        .nRST         (nRST),
        .valid_in     (m_valid),
        .op           (m_op),
        .seed         (m_seed),
        .tree_sum     (t_sum),
        .tree_valid   (t_valid),
        .result       (result),
        .result_valid (result_valid)
    );

endmodule

`default_nettype wire

// ==== bench/vred_checker.sv ====
`default_nettype none

module vred_checker (
    input  wire                    CLK,
    input  wire                    nRST,
    input  wire                    valid_in,
    input  wire vred_pkg::red_op_t op,
    input  wire [15:0]             test_idx,
    input  wire vred_pkg::elem_t   exp_result,
    input  wire vred_pkg::elem_t   result,
    input  wire                    result_valid,
    output int                     mismatch_count,
    output int                     timing_count,
    output int                     extra_count,
    output int                     pending
);

    // Sampling edges from a request to its visible result strobe
    localparam int latency = 8;

    int                cyc = 0;
    int                n_mismatch = 0;
    int                n_timing = 0;
    int                n_extra = 0;
    int                n_pending = 0;
    int                idx_q [$];
    vred_pkg::red_op_t op_q  [$];
    vred_pkg::elem_t   exp_q [$];
    int                cyc_q [$];

    assign mismatch_count = n_mismatch;
    assign timing_count   = n_timing;
    assign extra_count    = n_extra;
    assign pending        = n_pending;

    function automatic string op_label(input vred_pkg::red_op_t o);
        case (o)
            vred_pkg::red_sum: return "sum";
            vred_pkg::red_max: return "max";
            vred_pkg::red_min: return "min";
            default:           return "and";
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Result matching, in request order
    // ------------------------------------------------------------------
    always @(posedge CLK) begin : watch
        int                idx;
        int                t0;
        vred_pkg::red_op_t o;
        vred_pkg::elem_t   e;
        cyc = cyc + 1;
        if (!nRST) begin
            if (result_valid) begin
                n_extra++;
                $display("Result strobe seen while reset is asserted");
            end
        end else begin
            if (result_valid) begin
                if (idx_q.size() == 0) begin
                    n_extra++;
                    $display("Result strobe at cycle %0d with no request outstanding", cyc);
                end else begin
                    idx = idx_q.pop_front();
                    o   = op_q.pop_front();
                    e   = exp_q.pop_front();
                    t0  = cyc_q.pop_front();
                    if (cyc - t0 != latency) begin
                        n_timing++;
                        $display("Result of test %s_%0d came %0d cycles after its request, not %0d",
                                 op_label(o), idx, cyc - t0, latency);
                    end
                    if (result !== e) begin
                        n_mismatch++;
                        $display("Error: test %s_%0d expected %h actual %h",
                                 op_label(o), idx, e, result);
                    end
                end
            end
            if (valid_in) begin
                idx_q.push_back(int'(test_idx));
                op_q.push_back(op);
                exp_q.push_back(exp_result);
                cyc_q.push_back(cyc);
            end
        end
        n_pending = idx_q.size();
    end

endmodule

`default_nettype wire

// ==== bench/vred_tb.sv ====
`default_nettype none

module vred_tb;

    localparam int num_tests    = 22;
    localparam int rec_words    = 20;
    localparam int reset_cycles = 4;
    localparam int drain_cycles = 16;
    // Reset and every request with at most one idle cycle, plus drain room
    localparam int cycle_limit  = (reset_cycles + num_tests) * 2 + 40;

    logic              CLK;
    logic              nRST;
    logic              valid_in;
    vred_pkg::red_op_t op;
    vred_pkg::vlen_t   vl;
    vred_pkg::elem_t   seed;
    vred_pkg::elem_t   elems [vred_pkg::lanes];
    vred_pkg::elem_t   result;
    logic              result_valid;

    // Expected value and test number travel with each request
    vred_pkg::elem_t   exp_result;
    logic [15:0]       test_idx;

    logic [15:0]       tdata [num_tests * rec_words];
    int                cycle_count;
    integer            rand_seed;
    int                data_errors;
    int                leftover;
    int                mismatch_count;
    int                timing_count;
    int                extra_count;
    int                pending;

    vred_top u_vred_top (
        .CLK          (CLK),
        .nRST         (nRST),
        .valid_in     (valid_in),
        .op           (op),
        .vl           (vl),
        .seed         (seed),
        .elems        (elems),
        .result       (result),
        .result_valid (result_valid)
    );

    vred_checker u_checker (
        .CLK            (CLK),
        .nRST           (nRST),
        .valid_in       (valid_in),
        .op             (op),
        .test_idx       (test_idx),
        .exp_result     (exp_result),
        .result         (result),
        .result_valid   (result_valid),
        .mismatch_count (mismatch_count),
        .timing_count   (timing_count),
        .extra_count    (extra_count),
        .pending        (pending)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d results outstanding", cycle_count, pending);
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------
    // Test data
    // ------------------------------------------------------------------
    task automatic load_tests();
        int base;
        // Missing records keep this fill and show up as malformed
        for (int i = 0; i < num_tests * rec_words; i++) begin
            tdata[i] = 16'hc000 | 16'(i);
        end
        $readmemh("bench/vred_testdata.hex", tdata);
        for (int t = 0; t < num_tests; t++) begin
            base = t * rec_words;
            if (tdata[base] > 16'd3 || tdata[base + 1] > 16'd16) begin
                data_errors++;
                $display("Test data record %0d is missing or malformed", t);
            end
        end
    endtask

    task automatic drive_request(input int t);
        int base;
        base = t * rec_words;
        op   = vred_pkg::red_op_t'(tdata[base][1:0]);
        vl   = tdata[base + 1][4:0];
        seed = tdata[base + 2];
        for (int i = 0; i < vred_pkg::lanes; i++) begin
            elems[i] = tdata[base + 3 + i];
        end
        exp_result = tdata[base + 3 + vred_pkg::lanes];
        test_idx   = 16'(t);
        valid_in   = 1'b1;
    endtask

    // ------------------------------------------------------------------
    // Stimulus on the falling edge
    // ------------------------------------------------------------------
    initial begin : stimulus
        int gap;
        rand_seed   = 32'ha8c600a0;
        data_errors = 0;
        leftover    = 0;
        nRST        = 1'b0;
        valid_in    = 1'b0;
        op          = vred_pkg::red_sum;
        vl          = '0;
        seed        = '0;
        exp_result  = '0;
        test_idx    = '0;
        for (int i = 0; i < vred_pkg::lanes; i++) begin
            elems[i] = '0;
        end
        load_tests();
        repeat (reset_cycles) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        repeat (2) @(negedge CLK);

        for (int t = 0; t < num_tests; t++) begin
            drive_request(t);
            @(negedge CLK);
            // Opening requests run back to back
            if (t < 4) begin
                gap = 0;
            end else begin
                gap = $random(rand_seed) & 1;
            end
            if (gap != 0) begin
                valid_in = 1'b0;
                repeat (gap) @(negedge CLK);
            end
        end
        valid_in = 1'b0;

        // Quiet period, also catches stray result strobes
        repeat (drain_cycles) @(negedge CLK);
        leftover = pending;
        if (leftover != 0) begin
            $display("%0d expected results never arrived", leftover);
        end
        $display("Errors: %0d mismatch, %0d timing, %0d unexpected, %0d missing, %0d data",
                 mismatch_count, timing_count, extra_count, leftover, data_errors);
        if (mismatch_count + timing_count + extra_count + leftover + data_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vred.f ====
src/vred_pkg.sv
src/vred_lane_mask.sv
src/vred_pair_alu.sv
src/vred_tree.sv
src/vred_seed_combine.sv
src/vred_top.sv
bench/vred_checker.sv
bench/vred_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = vred_tb
FILELIST  = vred.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) bench/vred_testdata.hex
	@out="$$(./$(SIM))"; printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/vred_testdata.hex ====
// op vl seed e0 e1 .. e15 expected, all hex, one test per line
// vl is the active count, lanes from vl upward must not affect the result
0 10 0000 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010 0088
1 10 0000 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010 0010
2 10 0005 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010 0001
3 10 ffff 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010 0000
0 10 1000 0100 fff0 7000 8005 0030 ff00 1234 0002 8001 0fff fffe 0055 6000 0000 7ffe 8000 02ac
1 10 8000 0100 fff0 7000 8005 0030 ff00 1234 0002 8001 0fff fffe 0055 6000 0000 7ffe 8000 7ffe
2 10 7fff 0100 fff0 7000 8005 0030 ff00 1234 0002 8001 0fff fffe 0055 6000 0000 7ffe 8000 8000
3 10 ffff ffff fffe fffd fffb fff7 ffef ffdf ffbf ff7f feff fdff fbff f7ff efff dfff bfff 8000
2 10 c000 ffff fffe fffd fffb fff7 ffef ffdf ffbf ff7f feff fdff fbff f7ff efff dfff bfff bfff
1 03 8000 fff0 ff80 fffa 7fff 0000 1000 0000 7abc 0000 4000 0000 0001 0000 2000 0000 7f00 fffa
2 03 7fff fff0 ff80 fffa 7fff 0000 1000 0000 7abc 0000 4000 0000 0001 0000 2000 0000 7f00 ff80
3 03 ffff fff0 ff80 fffa 7fff 0000 1000 0000 7abc 0000 4000 0000 0001 0000 2000 0000 7f00 ff80
0 03 0000 fff0 ff80 fffa 7fff 0000 1000 0000 7abc 0000 4000 0000 0001 0000 2000 0000 7f00 ff6a
0 0f 0001 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 7fff 0f10
1 0f 8000 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 0101 7fff 0101
3 05 ffff ffff fffe fffd fffb fff7 ffef ffdf ffbf ff7f feff fdff fbff f7ff efff dfff bfff fff0
2 01 0200 0100 fff0 7000 8005 0030 ff00 1234 0002 8001 0fff fffe 0055 6000 0000 7ffe 8000 0100
0 01 1234 0100 fff0 7000 8005 0030 ff00 1234 0002 8001 0fff fffe 0055 6000 0000 7ffe 8000 1334
0 00 4321 0001 0002 0003 0004 0005 0006 0007 0008 0009 000a 000b 000c 000d 000e 000f 0010 4321
1 00 1357 0100 fff0 7000 8005 0030 ff00 1234 0002 8001 0fff fffe 0055 6000 0000 7ffe 8000 1357
2 00 8765 ffff fffe fffd fffb fff7 ffef ffdf ffbf ff7f feff fdff fbff f7ff efff dfff bfff 8765
3 00 00a5 fff0 ff80 fffa 7fff 0000 1000 0000 7abc 0000 4000 0000 0001 0000 2000 0000 7f00 00a5
